//--- hdl/cdr_defs.svh
`ifndef CDR_DEFS_SVH
`define CDR_DEFS_SVH

// Sample path widths
`define N_ADC           8
`define N_TI            4
`define N_PI            8
`define N_OUT           2
`define PHASE_EST_SHIFT 6
`define GAIN_W          3

// AXI4-Lite bus
`define AXI_AW          5
`define AXI_DW          32
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

// Register map
`define REG_CTRL        5'h00
`define REG_GAIN        5'h04
`define REG_PD_OFFSET   5'h08
`define REG_EXT_PI      5'h0C
`define REG_PHASE_SNAP  5'h10
`define REG_FREQ_SNAP   5'h14
`define REG_STATUS      5'h18

// Field positions
`define CTRL_EN_FREQ    0
`define CTRL_EN_EXT_PI  1
`define CTRL_SNAP_REQ   2
`define GAIN_KI_LSB     4

`endif

//--- hdl/cdr_pkg.sv
`include "cdr_defs.svh"

package cdr_pkg;

    // One ADC lane
    typedef logic signed [`N_ADC-1:0] adc_sample_t;

    // Timing error, two guard bits over a sample
    typedef logic signed [`N_ADC+1:0] pd_err_t;

    // Phase and frequency accumulators with fraction bits
    typedef logic signed [`N_ADC+1+`PHASE_EST_SHIFT:0] est_t;

    // Interpolator code
    typedef logic [`N_PI-1:0] pi_code_t;

endpackage

//--- hdl/cdr_ctrl_if.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

interface cdr_ctrl_if;
    import cdr_pkg::*;

    // Configuration from the register block
    logic [`GAIN_W-1:0] kp;
    logic [`GAIN_W-1:0] ki;
    pd_err_t            pd_offset;      // Read at top level by the detector
    logic               en_freq_est;
    logic               en_ext_pi;
    pi_code_t           ext_pi_ctl;
    logic               snap_req;

    // Loop state snapshot
    pd_err_t            phase_snap;     // Integer part of phase
    est_t               freq_snap;
    logic               snap_valid;

    modport csr (
        output kp, ki, pd_offset, en_freq_est, en_ext_pi, ext_pi_ctl, snap_req,
        input  phase_snap, freq_snap, snap_valid
    );

    modport loop (
        input  kp, ki, en_freq_est, en_ext_pi, ext_pi_ctl, snap_req,
        output phase_snap, freq_snap, snap_valid
    );

endinterface

//--- hdl/mm_pd.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module mm_pd (
    input  logic                 clk,
    input  logic                 ext_rstb,
    input  cdr_pkg::adc_sample_t din_i [`N_TI-1:0],
    input  cdr_pkg::pd_err_t     pd_offset_i,
    output cdr_pkg::pd_err_t     pd_err_o
);
    import cdr_pkg::*;

    localparam int SUM_W  = `N_ADC + 5;                 // Room for lane terms plus offset
    localparam int SAT_HI = (1 <<< (`N_ADC + 1)) - 1;
    localparam int SAT_LO = -(1 <<< (`N_ADC + 1));

    adc_sample_t             prev_w [`N_TI-1:0];
    adc_sample_t             last_q;                    // Last lane of previous word
    logic signed [SUM_W-1:0] cur_s;
    logic signed [SUM_W-1:0] prv_s;
    logic signed [SUM_W-1:0] acc_s;
    pd_err_t                 err_d;

    // Previous sample for each lane
    assign prev_w[0] = last_q;

    genvar k;
    generate
        for (k = 1; k < `N_TI; k++) begin : g_prev
            assign prev_w[k] = din_i[k-1];
        end
    endgenerate

    // x[k]*sgn(x[k-1]) - x[k-1]*sgn(x[k]), sign of zero is +1
    always_comb begin
        acc_s = SUM_W'(pd_offset_i);
        cur_s = '0;
        prv_s = '0;
        for (int i = 0; i < `N_TI; i++) begin
            cur_s = SUM_W'(din_i[i]);
            prv_s = SUM_W'(prev_w[i]);
            acc_s = acc_s + ((prv_s < 0) ? -cur_s : cur_s)
                          - ((cur_s < 0) ? -prv_s : prv_s);
        end
    end

    always_comb begin
        if (acc_s > SAT_HI) begin
            err_d = pd_err_t'(SAT_HI);
        end else if (acc_s < SAT_LO) begin
            err_d = pd_err_t'(SAT_LO);
        end else begin
            err_d = pd_err_t'(acc_s);
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q   <= '0;
            pd_err_o <= '0;
        end else begin
            last_q   <= din_i[`N_TI-1];
            pd_err_o <= err_d;
        end
    end

    a_err_known: assert property (@(posedge clk) disable iff (!ext_rstb)
        !$isunknown(pd_err_o));

endmodule

//--- hdl/cdr_loop_filter.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_loop_filter (
    input  logic              clk,
    input  logic              ext_rstb,
    input  cdr_pkg::pd_err_t  pd_err_i,
    cdr_ctrl_if.loop          ctrl,
    output cdr_pkg::pi_code_t pi_ctl_o [`N_OUT-1:0],
    output logic              freq_lvl_cross_o
);
    import cdr_pkg::*;

    typedef enum logic [1:0] {
        SNAP_SAMPLE = 2'd0,
        SNAP_WAIT   = 2'd1,
        SNAP_READY  = 2'd2
    } snap_state_t;

    snap_state_t snap_state;
    est_t        err_ext;
    est_t        phase_q;
    est_t        phase_d;
    est_t        freq_q;
    est_t        freq_d;
    est_t        freq_upd;
    est_t        prev_upd_q;
    pi_code_t    loop_code;

    assign err_ext = est_t'(pd_err_i);                  // Sign-extend before shift

    // Integral and proportional paths, both wrap in est_t
    always_comb begin
        freq_upd = freq_q + (err_ext <<< ctrl.ki);
        freq_d   = ctrl.en_freq_est ? freq_upd : '0;
        phase_d  = phase_q + (err_ext <<< ctrl.kp) + freq_q;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_q          <= '0;
            freq_q           <= '0;
            prev_upd_q       <= '0;
            freq_lvl_cross_o <= 1'b0;
        end else begin
            phase_q          <= phase_d;
            freq_q           <= freq_d;
            prev_upd_q       <= freq_upd;
            freq_lvl_cross_o <= (freq_upd > prev_upd_q);  // Rising frequency estimate
        end
    end

    assign loop_code = phase_q[$bits(est_t)-1 -: `N_PI];

    always_comb begin
        for (int i = 0; i < `N_OUT; i++) begin
            pi_ctl_o[i] = ctrl.en_ext_pi ? ctrl.ext_pi_ctl : loop_code;
        end
    end

    // One-shot capture of the loop state per request edge
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            snap_state      <= SNAP_WAIT;
            ctrl.phase_snap <= '0;
            ctrl.freq_snap  <= '0;
            ctrl.snap_valid <= 1'b0;
        end else begin
            case (snap_state)
                SNAP_WAIT: begin
                    if (!ctrl.snap_req) begin
                        snap_state      <= SNAP_READY;
                        ctrl.snap_valid <= 1'b0;      // Rearmed
                    end
                end
                SNAP_READY: begin
                    if (ctrl.snap_req) begin
                        snap_state <= SNAP_SAMPLE;
                    end
                end
                SNAP_SAMPLE: begin
                    ctrl.phase_snap <= pd_err_t'(phase_q >>> `PHASE_EST_SHIFT);
                    ctrl.freq_snap  <= freq_upd;
                    ctrl.snap_valid <= 1'b1;
                    snap_state      <= SNAP_WAIT;
                end
                default: begin
                    snap_state <= SNAP_WAIT;
                end
            endcase
        end
    end

    a_snap_state_legal: assert property (@(posedge clk) disable iff (!ext_rstb)
        snap_state inside {SNAP_SAMPLE, SNAP_WAIT, SNAP_READY});

endmodule

//--- hdl/cdr_csr.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_csr (
    input  logic                 clk,
    input  logic                 ext_rstb,
    input  logic [`AXI_AW-1:0]   s_axi_awaddr_i,
    input  logic                 s_axi_awvalid_i,
    output logic                 s_axi_awready_o,
    input  logic [`AXI_DW-1:0]   s_axi_wdata_i,
    input  logic [`AXI_DW/8-1:0] s_axi_wstrb_i,
    input  logic                 s_axi_wvalid_i,
    output logic                 s_axi_wready_o,
    output logic [1:0]           s_axi_bresp_o,
    output logic                 s_axi_bvalid_o,
    input  logic                 s_axi_bready_i,
    input  logic [`AXI_AW-1:0]   s_axi_araddr_i,
    input  logic                 s_axi_arvalid_i,
    output logic                 s_axi_arready_o,
    output logic [`AXI_DW-1:0]   s_axi_rdata_o,
    output logic [1:0]           s_axi_rresp_o,
    output logic                 s_axi_rvalid_o,
    input  logic                 s_axi_rready_i,
    cdr_ctrl_if.csr              ctrl
);
    import cdr_pkg::*;

    localparam int OFS_W = $bits(pd_err_t);
    localparam int PI_W  = $bits(pi_code_t);

    logic                 live_q;                       // Out of reset
    logic                 aw_done;
    logic                 w_done;
    logic [`AXI_AW-1:0]   awaddr_q;
    logic [`AXI_DW-1:0]   wdata_q;
    logic [`AXI_DW/8-1:0] wstrb_q;
    logic                 wr_ok;
    logic                 rd_ok;
    logic [`AXI_DW-1:0]   rd_word;

    assign s_axi_awready_o = live_q && !aw_done && !s_axi_bvalid_o;
    assign s_axi_wready_o  = live_q && !w_done && !s_axi_bvalid_o;
    assign s_axi_arready_o = live_q && !s_axi_rvalid_o;

    assign wr_ok = awaddr_q inside {`REG_CTRL, `REG_GAIN, `REG_PD_OFFSET, `REG_EXT_PI};

    // Captured write channels
    always_ff @(posedge clk) begin
        if (s_axi_awvalid_i && s_axi_awready_o) begin
            awaddr_q <= s_axi_awaddr_i;
        end
        if (s_axi_wvalid_i && s_axi_wready_o) begin
            wdata_q <= s_axi_wdata_i;
            wstrb_q <= s_axi_wstrb_i;
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            live_q           <= 1'b0;
            aw_done          <= 1'b0;
            w_done           <= 1'b0;
            s_axi_bvalid_o   <= 1'b0;
            s_axi_bresp_o    <= `AXI_RESP_OKAY;
            ctrl.en_freq_est <= 1'b0;
            ctrl.en_ext_pi   <= 1'b0;
            ctrl.snap_req    <= 1'b0;
            ctrl.kp          <= '0;
            ctrl.ki          <= '0;
            ctrl.pd_offset   <= '0;
            ctrl.ext_pi_ctl  <= '0;
        end else begin
            live_q <= 1'b1;
            if (s_axi_awvalid_i && s_axi_awready_o) begin
                aw_done <= 1'b1;
            end
            if (s_axi_wvalid_i && s_axi_wready_o) begin
                w_done <= 1'b1;
            end
            if (aw_done && w_done) begin
                aw_done        <= 1'b0;
                w_done         <= 1'b0;
                s_axi_bvalid_o <= 1'b1;
                s_axi_bresp_o  <= wr_ok ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
                case (awaddr_q)
                    `REG_CTRL: begin
                        if (wstrb_q[0]) begin
                            ctrl.en_freq_est <= wdata_q[`CTRL_EN_FREQ];
                            ctrl.en_ext_pi   <= wdata_q[`CTRL_EN_EXT_PI];
                            ctrl.snap_req    <= wdata_q[`CTRL_SNAP_REQ];
                        end
                    end
                    `REG_GAIN: begin
                        if (wstrb_q[0]) begin
                            ctrl.kp <= wdata_q[`GAIN_W-1:0];
                            ctrl.ki <= wdata_q[`GAIN_KI_LSB +: `GAIN_W];
                        end
                    end
                    `REG_PD_OFFSET: begin
                        for (int b = 0; b < OFS_W; b++) begin
                            if (wstrb_q[b/8]) begin
                                ctrl.pd_offset[b] <= wdata_q[b];
                            end
                        end
                    end
                    `REG_EXT_PI: begin
                        for (int b = 0; b < PI_W; b++) begin
                            if (wstrb_q[b/8]) begin
                                ctrl.ext_pi_ctl[b] <= wdata_q[b];
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end else if (s_axi_bvalid_o && s_axi_bready_i) begin
                s_axi_bvalid_o <= 1'b0;
            end
        end
    end

    // Read decode, snapshots sign-extended
    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        case (s_axi_araddr_i)
            `REG_CTRL: begin
                rd_word[`CTRL_EN_FREQ]   = ctrl.en_freq_est;
                rd_word[`CTRL_EN_EXT_PI] = ctrl.en_ext_pi;
                rd_word[`CTRL_SNAP_REQ]  = ctrl.snap_req;
            end
            `REG_GAIN: begin
                rd_word[`GAIN_W-1:0]             = ctrl.kp;
                rd_word[`GAIN_KI_LSB +: `GAIN_W] = ctrl.ki;
            end
            `REG_PD_OFFSET:  rd_word[OFS_W-1:0] = ctrl.pd_offset;
            `REG_EXT_PI:     rd_word[PI_W-1:0]  = ctrl.ext_pi_ctl;
            `REG_PHASE_SNAP: rd_word = `AXI_DW'(ctrl.phase_snap);
            `REG_FREQ_SNAP:  rd_word = `AXI_DW'(ctrl.freq_snap);
            `REG_STATUS:     rd_word[0] = ctrl.snap_valid;
            default:         rd_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            s_axi_rvalid_o <= 1'b0;
            s_axi_rresp_o  <= `AXI_RESP_OKAY;
        end else if (s_axi_arvalid_i && s_axi_arready_o) begin
            s_axi_rvalid_o <= 1'b1;
            s_axi_rresp_o  <= rd_ok ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
        end else if (s_axi_rvalid_o && s_axi_rready_i) begin
            s_axi_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_axi_arvalid_i && s_axi_arready_o) begin
            s_axi_rdata_o <= rd_word;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!ext_rstb)
        s_axi_bvalid_o && !s_axi_bready_i |=> s_axi_bvalid_o);

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!ext_rstb)
        s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o);

endmodule

//--- hdl/cdr_top.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module cdr_top (
    input  logic                 clk,
    input  logic                 ext_rstb,
    input  cdr_pkg::adc_sample_t din_i [`N_TI-1:0],
    input  logic [`AXI_AW-1:0]   s_axi_awaddr_i,
    input  logic                 s_axi_awvalid_i,
    output logic                 s_axi_awready_o,
    input  logic [`AXI_DW-1:0]   s_axi_wdata_i,
    input  logic [`AXI_DW/8-1:0] s_axi_wstrb_i,
    input  logic                 s_axi_wvalid_i,
    output logic                 s_axi_wready_o,
    output logic [1:0]           s_axi_bresp_o,
    output logic                 s_axi_bvalid_o,
    input  logic                 s_axi_bready_i,
    input  logic [`AXI_AW-1:0]   s_axi_araddr_i,
    input  logic                 s_axi_arvalid_i,
    output logic                 s_axi_arready_o,
    output logic [`AXI_DW-1:0]   s_axi_rdata_o,
    output logic [1:0]           s_axi_rresp_o,
    output logic                 s_axi_rvalid_o,
    input  logic                 s_axi_rready_i,
    output cdr_pkg::pi_code_t    pi_ctl_o [`N_OUT-1:0],
    output logic                 freq_lvl_cross_o
);
    import cdr_pkg::*;

    pd_err_t pd_err;

    cdr_ctrl_if ctrl_if ();

    mm_pd mm_pd_i (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (ctrl_if.pd_offset),
        .pd_err_o    (pd_err)
    );

    cdr_loop_filter cdr_loop_filter_i (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_err_i         (pd_err),
        .ctrl             (ctrl_if.loop),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o)
    );

    cdr_csr cdr_csr_i (
        .clk             (clk),
        .ext_rstb        (ext_rstb),
        .s_axi_awaddr_i  (s_axi_awaddr_i),
        .s_axi_awvalid_i (s_axi_awvalid_i),
        .s_axi_awready_o (s_axi_awready_o),
        .s_axi_wdata_i   (s_axi_wdata_i),
        .s_axi_wstrb_i   (s_axi_wstrb_i),
        .s_axi_wvalid_i  (s_axi_wvalid_i),
        .s_axi_wready_o  (s_axi_wready_o),
        .s_axi_bresp_o   (s_axi_bresp_o),
        .s_axi_bvalid_o  (s_axi_bvalid_o),
        .s_axi_bready_i  (s_axi_bready_i),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .ctrl            (ctrl_if.csr)
    );

endmodule

//--- testbench/tb_cdr_top.sv
`timescale 1ns/1ps
`include "cdr_defs.svh"

module tb_cdr_top;
    import cdr_pkg::*;

    localparam int EST_W     = `N_ADC + 2 + `PHASE_EST_SHIFT;
    localparam int MAX_CYCLE = 6000;
    localparam int S_WAIT    = 0;
    localparam int S_READY   = 1;
    localparam int S_SAMPLE  = 2;

    logic                 clk;
    logic                 ext_rstb;
    adc_sample_t          din_i [`N_TI-1:0];
    logic [`AXI_AW-1:0]   s_axi_awaddr_i, s_axi_araddr_i;
    logic [`AXI_DW-1:0]   s_axi_wdata_i, s_axi_rdata_o;
    logic [`AXI_DW/8-1:0] s_axi_wstrb_i;
    logic                 s_axi_awvalid_i, s_axi_wvalid_i, s_axi_bready_i;
    logic                 s_axi_arvalid_i, s_axi_rready_i;
    logic                 s_axi_awready_o, s_axi_wready_o, s_axi_bvalid_o;
    logic                 s_axi_arready_o, s_axi_rvalid_o;
    logic [1:0]           s_axi_bresp_o, s_axi_rresp_o;
    pi_code_t             pi_ctl_o [`N_OUT-1:0];
    logic                 freq_lvl_cross_o;

    // Shadow of the control registers
    logic     sh_en_freq, sh_en_ext, sh_snap_req;
    int       sh_kp, sh_ki, sh_offset;
    pi_code_t sh_ext_pi;

    // Reference model state
    int                      m_err, m_last, m_snap_state, m_phase_snap, m_freq_snap;
    logic signed [EST_W-1:0] m_phase, m_freq, m_prev_upd, m_upd, m_phase_nx;
    logic                    m_cross;
    logic [`N_TI*`N_ADC-1:0] m_word;

    logic [15:0] lfsr_q;
    logic        rand_en;
    pi_code_t    exp_code;
    int          cycle_count, pass_count, fail_count, test_fails;
    int          mdl_lane, cmp_lane, drv_lane;

    cdr_top cdr_top_i (.*);

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic draw_sample(output adc_sample_t smp);
        int b;
        for (b = 0; b < `N_ADC; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            smp[b] = lfsr_q[0];
        end
    endtask

    function automatic int sign_of(input int x);
        return (x < 0) ? -1 : 1;                         // Zero counts as positive
    endfunction

    // Mueller-Muller error of one word, saturated to the error range
    function automatic int mm_error(input logic [`N_TI*`N_ADC-1:0] word,
                                    input int prev_last, input int offset);
        int sum;
        int prev;
        int cur;
        int k;
        int lim;
        lim  = 1 << (`N_ADC + 1);
        sum  = offset;
        prev = prev_last;
        for (k = 0; k < `N_TI; k++) begin
            cur  = $signed(word[k*`N_ADC +: `N_ADC]);
            sum  = sum + cur * sign_of(prev) - prev * sign_of(cur);
            prev = cur;
        end
        if (sum > lim - 1) begin
            sum = lim - 1;
        end else if (sum < -lim) begin
            sum = -lim;
        end
        return sum;
    endfunction

    function automatic logic signed [EST_W-1:0] wrap_est(input longint x);
        return x[EST_W-1:0];
    endfunction

    function automatic void apply_shadow(input logic [`AXI_AW-1:0] addr,
                                         input logic [`AXI_DW-1:0] data);
        case (addr)
            `REG_CTRL: begin
                sh_en_freq  = data[`CTRL_EN_FREQ];
                sh_en_ext   = data[`CTRL_EN_EXT_PI];
                sh_snap_req = data[`CTRL_SNAP_REQ];
            end
            `REG_GAIN: begin
                sh_kp = data[`GAIN_W-1:0];
                sh_ki = data[`GAIN_KI_LSB +: `GAIN_W];
            end
            `REG_PD_OFFSET: sh_offset = $signed(data[`N_ADC+1:0]);
            `REG_EXT_PI:    sh_ext_pi = data[`N_PI-1:0];
            default: begin
            end
        endcase
    endfunction

    task automatic compare_value(input string name, input longint expv, input longint actv);
        if (actv != expv) begin
            fail_count++;
            $display("[FAIL] %0t ns %s expected 0x%0h actual 0x%0h", $time, name, expv, actv);
        end else begin
            pass_count++;
        end
    endtask

    task automatic write_reg(input logic [`AXI_AW-1:0] addr, input logic [`AXI_DW-1:0] data,
                             output logic [1:0] resp);
        logic aw_pend;
        logic w_pend;
        logic aw_fire;
        logic w_fire;
        @(posedge clk);
        #2;
        s_axi_awaddr_i  = addr;
        s_axi_awvalid_i = 1'b1;
        s_axi_wdata_i   = data;
        s_axi_wvalid_i  = 1'b1;
        s_axi_bready_i  = 1'b1;
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        while (aw_pend || w_pend) begin
            @(negedge clk);
            aw_fire = s_axi_awvalid_i && s_axi_awready_o;
            w_fire  = s_axi_wvalid_i && s_axi_wready_o;
            @(posedge clk);
            #2;
            if (aw_fire) begin
                aw_pend         = 1'b0;
                s_axi_awvalid_i = 1'b0;
            end
            if (w_fire) begin
                w_pend         = 1'b0;
                s_axi_wvalid_i = 1'b0;
            end
        end
        while (!s_axi_bvalid_o) begin
            @(posedge clk);
            #1;
        end
        resp = s_axi_bresp_o;
        apply_shadow(addr, data);                        // Register took the value at this edge
        @(posedge clk);
        #2;
        s_axi_bready_i = 1'b0;
    endtask

    task automatic read_reg(input logic [`AXI_AW-1:0] addr, output logic [`AXI_DW-1:0] data,
                            output logic [1:0] resp);
        logic fire;
        @(posedge clk);
        #2;
        s_axi_araddr_i  = addr;
        s_axi_arvalid_i = 1'b1;
        s_axi_rready_i  = 1'b1;
        fire = 1'b0;
        while (!fire) begin
            @(negedge clk);
            fire = s_axi_arready_o;
            @(posedge clk);
            #2;
        end
        s_axi_arvalid_i = 1'b0;
        while (!s_axi_rvalid_o) begin
            @(posedge clk);
            #1;
        end
        data = s_axi_rdata_o;
        resp = s_axi_rresp_o;
        @(posedge clk);
        #2;
        s_axi_rready_i = 1'b0;
    endtask

    task automatic expect_write(input logic [`AXI_AW-1:0] addr, input logic [`AXI_DW-1:0] data,
                                input logic [1:0] exp_resp);
        logic [1:0] resp;
        write_reg(addr, data, resp);
        compare_value($sformatf("s_axi_bresp_o@0x%0h", addr), exp_resp, resp);
    endtask

    task automatic expect_read(input logic [`AXI_AW-1:0] addr, input logic [`AXI_DW-1:0] expv,
                               input logic [1:0] exp_resp);
        logic [`AXI_DW-1:0] data;
        logic [1:0]         resp;
        read_reg(addr, data, resp);
        compare_value($sformatf("s_axi_rresp_o@0x%0h", addr), exp_resp, resp);
        if (exp_resp == `AXI_RESP_OKAY) begin
            compare_value($sformatf("s_axi_rdata_o@0x%0h", addr), expv, data);
        end
    endtask

    task automatic report_test(input string name);
        if (fail_count == test_fails) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, fail_count - test_fails);
        end
        test_fails = fail_count;
    endtask

    // Model registers step on the same edges as the DUT
    always @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            m_err        = 0;
            m_last       = 0;
            m_phase      = '0;
            m_freq       = '0;
            m_prev_upd   = '0;
            m_cross      = 1'b0;
            m_snap_state = S_WAIT;
            m_phase_snap = 0;
            m_freq_snap  = 0;
        end else begin
            m_upd      = wrap_est(longint'(m_freq) + (longint'(m_err) <<< sh_ki));
            m_phase_nx = wrap_est(longint'(m_phase) + (longint'(m_err) <<< sh_kp)
                                  + longint'(m_freq));
            case (m_snap_state)
                S_WAIT: begin
                    if (!sh_snap_req) begin
                        m_snap_state = S_READY;
                    end
                end
                S_READY: begin
                    if (sh_snap_req) begin
                        m_snap_state = S_SAMPLE;
                    end
                end
                default: begin
                    m_phase_snap = int'(m_phase) >>> `PHASE_EST_SHIFT;
                    m_freq_snap  = int'(m_upd);
                    m_snap_state = S_WAIT;
                end
            endcase
            m_cross    = (m_upd > m_prev_upd);
            m_prev_upd = m_upd;
            m_freq     = sh_en_freq ? m_upd : '0;
            m_phase    = m_phase_nx;
            for (mdl_lane = 0; mdl_lane < `N_TI; mdl_lane++) begin
                m_word[mdl_lane*`N_ADC +: `N_ADC] = din_i[mdl_lane];
            end
            m_err  = mm_error(m_word, m_last, sh_offset);
            m_last = din_i[`N_TI-1];
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (ext_rstb) begin
            exp_code = sh_en_ext ? sh_ext_pi : pi_code_t'(m_phase[EST_W-1 -: `N_PI]);
            for (cmp_lane = 0; cmp_lane < `N_OUT; cmp_lane++) begin
                compare_value($sformatf("pi_ctl_o[%0d]", cmp_lane), exp_code, pi_ctl_o[cmp_lane]);
            end
            compare_value("freq_lvl_cross_o", m_cross, freq_lvl_cross_o);
        end
    end

    always @(posedge clk) begin
        #2;
        if (rand_en) begin
            for (drv_lane = 0; drv_lane < `N_TI; drv_lane++) begin
                draw_sample(din_i[drv_lane]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLE) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        int                 i;
        int                 a;
        int                 polls;
        logic [`AXI_DW-1:0] rdata;
        logic [1:0]         resp;
        clk             = 1'b0;
        ext_rstb        = 1'b0;
        s_axi_awaddr_i  = '0;
        s_axi_awvalid_i = 1'b0;
        s_axi_wdata_i   = '0;
        s_axi_wstrb_i   = '1;
        s_axi_wvalid_i  = 1'b0;
        s_axi_bready_i  = 1'b0;
        s_axi_araddr_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        for (i = 0; i < `N_TI; i++) begin
            din_i[i] = '0;
        end
        sh_en_freq  = 1'b0;
        sh_en_ext   = 1'b0;
        sh_snap_req = 1'b0;
        sh_kp       = 0;
        sh_ki       = 0;
        sh_offset   = 0;
        sh_ext_pi   = '0;
        lfsr_q      = 16'd19206;
        rand_en     = 1'b0;
        cycle_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_fails  = 0;
        repeat (16) @(posedge clk);
        #2;
        compare_value("s_axi_awready_o", 0, s_axi_awready_o);   // Bus idle while in reset
        compare_value("s_axi_wready_o", 0, s_axi_wready_o);
        compare_value("s_axi_arready_o", 0, s_axi_arready_o);
        compare_value("s_axi_bvalid_o", 0, s_axi_bvalid_o);
        compare_value("s_axi_rvalid_o", 0, s_axi_rvalid_o);
        ext_rstb = 1'b1;

        @(negedge clk);
        for (i = 0; i < `N_OUT; i++) begin
            compare_value($sformatf("pi_ctl_o[%0d]", i), 0, pi_ctl_o[i]);
        end
        compare_value("freq_lvl_cross_o", 0, freq_lvl_cross_o);
        for (a = 0; a <= `REG_STATUS; a += 4) begin
            expect_read(`AXI_AW'(a), '0, `AXI_RESP_OKAY);
        end
        report_test("1 reset state");

        expect_write(`REG_GAIN, 32'h53, `AXI_RESP_OKAY);
        expect_write(`REG_PD_OFFSET, 32'h2A5, `AXI_RESP_OKAY);
        expect_write(`REG_EXT_PI, 32'hC3, `AXI_RESP_OKAY);
        expect_write(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
        expect_read(`REG_GAIN, 32'h53, `AXI_RESP_OKAY);
        expect_read(`REG_PD_OFFSET, 32'h2A5, `AXI_RESP_OKAY);
        expect_read(`REG_EXT_PI, 32'hC3, `AXI_RESP_OKAY);
        expect_read(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
        expect_read(5'h1C, '0, `AXI_RESP_SLVERR);     // Hole in the map
        expect_write(`REG_STATUS, 32'h1, `AXI_RESP_SLVERR);
        report_test("2 register access");

        expect_write(`REG_EXT_PI, 32'h5A, `AXI_RESP_OKAY);
        expect_write(`REG_CTRL, 32'h2, `AXI_RESP_OKAY);
        repeat (4) begin
            @(negedge clk);
            for (i = 0; i < `N_OUT; i++) begin
                compare_value($sformatf("pi_ctl_o[%0d]", i), 8'h5A, pi_ctl_o[i]);
            end
        end
        expect_write(`REG_CTRL, 32'h0, `AXI_RESP_OKAY);
        repeat (4) @(negedge clk);
        report_test("3 override");

        expect_write(`REG_GAIN, 32'h01, `AXI_RESP_OKAY);
        expect_write(`REG_PD_OFFSET, 32'h5, `AXI_RESP_OKAY);
        @(negedge clk);
        rand_en = 1'b1;
        repeat (400) @(posedge clk);
        report_test("4 proportional tracking");

        expect_write(`REG_GAIN, 32'h12, `AXI_RESP_OKAY);  // Kp 2, Ki 1
        expect_write(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
        repeat (400) @(posedge clk);
        @(negedge clk);
        rand_en = 1'b0;                                     // Word held from here on
        expect_write(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
        expect_write(`REG_CTRL, 32'h5, `AXI_RESP_OKAY);
        polls = 0;
        rdata = '0;
        while (!rdata[0] && polls < 16) begin
            read_reg(`REG_STATUS, rdata, resp);
            polls++;
        end
        if (!rdata[0]) begin
            fail_count++;
            $display("snapshot was never captured, status bit 0 stayed low");
        end else begin
            expect_read(`REG_PHASE_SNAP, `AXI_DW'(m_phase_snap), `AXI_RESP_OKAY);
            expect_read(`REG_FREQ_SNAP, `AXI_DW'(m_freq_snap), `AXI_RESP_OKAY);
        end
        report_test("5 second-order loop and snapshot");

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+hdl
hdl/cdr_pkg.sv
hdl/cdr_ctrl_if.sv
hdl/mm_pd.sv
hdl/cdr_loop_filter.sv
hdl/cdr_csr.sv
hdl/cdr_top.sv
testbench/tb_cdr_top.sv
